/* bench/genx_qspi_model.sv */
`timescale 1ns/100ps

module genx_qspi_model (
    input  logic                  sck,
    input  qspi_bus_pkg::nybble_t mosi,
    output qspi_bus_pkg::nybble_t miso,
    input  logic                  host_csn,
    input  logic                  bank_csn,
    output logic [31:0]           bank_en_seen,
    output int                    host_windows,
    output int                    bank_windows
);

    // Register contents kept in wire byte order
    logic [31:0]           host_regs [0:255];
    logic [31:0]           bank_regs [0:255];
    // Nybbles seen in the current chip select window
    qspi_bus_pkg::nybble_t nyb [0:39];
    int                    rise_cnt;
    logic                  active;
    logic                  on_bank;

    // Eight nybbles from index first, earliest on top
    function automatic logic [31:0] wire_word(input int first);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            w = {w[27:0], nyb[first + i]};
        end
        return w;
    endfunction

    // Address goes little-endian on the wire
    function automatic logic [31:0] byte_swap(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    // Opcode sits in bit 0 of the first eight nybbles, MSB first
    function automatic logic [7:0] window_opcode();
        logic [7:0] op;
        op = '0;
        for (int i = 0; i < 8; i++) begin
            op = {op[6:0], nyb[i][0]};
        end
        return op;
    endfunction

    // Read data goes out in nybbles 32 to 39, after the turnaround
    function automatic qspi_bus_pkg::nybble_t read_nybble(input int k);
        logic [31:0] addr;
        logic [31:0] word;
        if (k < 32 || k > 39 || window_opcode() != qspi_bus_pkg::OP_READ_SINGLE) begin
            return '0;
        end
        addr = byte_swap(wire_word(8));
        word = on_bank ? bank_regs[addr[9:2]] : host_regs[addr[9:2]];
        return word[31 - 4*(k - 32) -: 4];
    endfunction

    initial begin
        miso         = '0;
        bank_en_seen = '0;
        host_windows = 0;
        bank_windows = 0;
        rise_cnt     = 0;
        active       = 1'b0;
        on_bank      = 1'b0;
        // Fill differs per index and per array
        for (int i = 0; i < 256; i++) begin
            host_regs[i] = 32'h4800_0000 | i;
            bank_regs[i] = 32'hb400_0000 | i;
        end
    end

    // ====================
    // Window tracking
    // ====================
    always @(negedge host_csn or negedge bank_csn) begin
        if (host_csn === 1'b0 || bank_csn === 1'b0) begin
            active   = 1'b1;
            on_bank  = (bank_csn === 1'b0);
            rise_cnt = 0;
            miso     = '0;
            if (on_bank) begin
                bank_windows++;
            end else begin
                host_windows++;
            end
        end
    end

    // Device samples mosi on the rising sck edge
    always @(posedge sck) begin
        if (active && rise_cnt < 40) begin
            nyb[rise_cnt] = mosi;
        end
        if (active) begin
            rise_cnt++;
        end
    end

    // miso moves on the falling edge, ready for the next rise
    always @(negedge sck) begin
        if (active) begin
            miso = read_nybble(rise_cnt);
        end
    end

    // Decode once both chip selects are back high
    always @(posedge host_csn or posedge bank_csn) begin : window_end
        logic [31:0] addr;
        logic [31:0] data;
        if (active && host_csn === 1'b1 && bank_csn === 1'b1) begin
            active = 1'b0;
            miso   = '0;
            addr   = byte_swap(wire_word(8));
            data   = wire_word(16);
            // Only a complete single write touches a register
            if (window_opcode() == qspi_bus_pkg::OP_WRITE_SINGLE &&
                rise_cnt == qspi_bus_pkg::WREG_CLKS) begin
                if (on_bank) begin
                    bank_regs[addr[9:2]] = data;
                end else begin
                    host_regs[addr[9:2]] = data;
                    if (addr == qspi_cmd_pkg::BANK_EN_REG) begin
                        bank_en_seen = byte_swap(data);
                    end
                end
            end
        end
    end

endmodule

/* bench/tb_qspi_manager.sv */
`timescale 1ns/100ps

module tb_qspi_manager;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CLKS     = 5;
    localparam int IDLE_WAIT_CLKS = 1000;

    // Short names for the table rows
    localparam logic [2:0] WR_H = qspi_cmd_pkg::CMD_WR_HREG;
    localparam logic [2:0] RD_H = qspi_cmd_pkg::CMD_RD_HREG;
    localparam logic [2:0] WR_B = qspi_cmd_pkg::CMD_WR_BREG;
    localparam logic [2:0] RD_B = qspi_cmd_pkg::CMD_RD_BREG;
    localparam qspi_cmd_pkg::qspi_err_e E_OK    = qspi_cmd_pkg::ERR_NONE;
    localparam qspi_cmd_pkg::qspi_err_e E_BANK  = qspi_cmd_pkg::ERR_BANKSEL;
    localparam qspi_cmd_pkg::qspi_err_e E_ADDR  = qspi_cmd_pkg::ERR_ADDRESS;
    localparam qspi_cmd_pkg::qspi_err_e E_ALIGN = qspi_cmd_pkg::ERR_UNALIGNED;
    localparam qspi_cmd_pkg::qspi_err_e E_CMD   = qspi_cmd_pkg::ERR_BAD_CMD;

    // One stimulus row with its expected outcome
    // slot links a write to the read that checks it
    typedef struct packed {
        logic [2:0]               cmd;
        qspi_cmd_pkg::bankmap_t   bankmap;
        qspi_cmd_pkg::qspi_addr_t addr;
        logic [1:0]               slot;
        qspi_cmd_pkg::qspi_err_e  exp_err;
        logic [1:0]               exp_host;
        logic [1:0]               exp_bank;
    } test_row_t;

    logic                     clk;
    logic                     resetn;
    qspi_cmd_pkg::qspi_req_t  req;
    qspi_cmd_pkg::qspi_rsp_t  rsp;
    qspi_bus_pkg::nybble_t    mosi;
    qspi_bus_pkg::nybble_t    miso;
    logic                     sck;
    logic                     host_csn;
    logic                     bank_csn;
    logic [31:0]              bank_en_seen;
    int                       host_windows;
    int                       bank_windows;

    test_row_t                table_q [$];
    qspi_cmd_pkg::qspi_word_t slot_val [0:3];
    integer                   seed;
    int                       n_tests;
    int                       err_count;
    int                       n_run;
    int                       n_bad;

    qspi_manager uut (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req),
        .rsp      (rsp),
        .mosi     (mosi),
        .miso     (miso),
        .sck      (sck),
        .host_csn (host_csn),
        .bank_csn (bank_csn)
    );

    genx_qspi_model u_model (
        .sck          (sck),
        .mosi         (mosi),
        .miso         (miso),
        .host_csn     (host_csn),
        .bank_csn     (bank_csn),
        .bank_en_seen (bank_en_seen),
        .host_windows (host_windows),
        .bank_windows (bank_windows)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic add_row(input logic [2:0] cmd, input logic [9:0] map,
                           input logic [31:0] addr, input logic [1:0] slot,
                           input qspi_cmd_pkg::qspi_err_e err,
                           input logic [1:0] nh, input logic [1:0] nb);
        test_row_t row;
        row.cmd      = cmd;
        row.bankmap  = map;
        row.addr     = addr;
        row.slot     = slot;
        row.exp_err  = err;
        row.exp_host = nh;
        row.exp_bank = nb;
        table_q.push_back(row);
    endtask

    function automatic string cmd_name(input logic [2:0] cmd);
        case (cmd)
            WR_H:    return "wr_hreg";
            RD_H:    return "rd_hreg";
            WR_B:    return "wr_breg";
            RD_B:    return "rd_breg";
            default: return "bad_cmd";
        endcase
    endfunction

    // ====================
    // One command
    // ====================
    task automatic apply_row(input test_row_t row, input int n);
        int                       errs_before;
        int                       host_before;
        int                       bank_before;
        int                       waited;
        logic                     is_read;
        logic                     is_bank;
        qspi_cmd_pkg::qspi_word_t wdata;
        errs_before = err_count;
        host_before = host_windows;
        bank_before = bank_windows;
        wdata       = $random(seed);
        is_read     = (row.cmd == RD_H) || (row.cmd == RD_B);
        is_bank     = (row.cmd == WR_B) || (row.cmd == RD_B);

        // Single clk start pulse
        @(negedge clk);
        req.cmd     = qspi_cmd_pkg::qspi_cmd_e'(row.cmd);
        req.bankmap = row.bankmap;
        req.addr    = row.addr;
        req.wdata   = wdata;
        req.start   = 1'b1;
        @(negedge clk);
        req.start = 1'b0;
        #1;
        // Busy if accepted, back to idle with the code if rejected
        check_value("idle after start", rsp.idle, row.exp_err != E_OK);

        waited = 0;
        while (!rsp.idle && waited < IDLE_WAIT_CLKS) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp.idle) begin
            $display("Test %0d: the DUT did not return to idle in time", n);
            err_count++;
        end

        check_value("error code", rsp.err, row.exp_err);
        check_value("host windows", host_windows - host_before, row.exp_host);
        check_value("bank windows", bank_windows - bank_before, row.exp_bank);
        check_value("host_csn", host_csn, 1'b1);
        check_value("bank_csn", bank_csn, 1'b1);
        check_value("mosi", mosi, 4'h0);
        if (row.exp_err == E_OK) begin
            if (is_bank) begin
                check_value("bank enable write", bank_en_seen, 32'(row.bankmap));
            end
            if (is_read) begin
                check_value("read data", rsp.rdata, slot_val[row.slot]);
            end else begin
                slot_val[row.slot] = wdata;
            end
        end

        n_run++;
        if (err_count == errs_before) begin
            $display("test %2d %s map %h addr %h: ok", n, cmd_name(row.cmd), row.bankmap,
                     row.addr);
        end else begin
            n_bad++;
            $display("test %2d %s map %h addr %h: mismatch", n, cmd_name(row.cmd),
                     row.bankmap, row.addr);
        end
    endtask

    // Run limit of 1000 clk per table row
    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 1000 + RESET_CLKS + 10) @(posedge clk);
        $display("Watchdog expired before the %0d tests completed", n_tests);
        $display("** FAIL **");
        $finish;
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        seed      = 32'ha50b_b04a;
        err_count = 0;
        n_run     = 0;
        n_bad     = 0;
        n_tests   = 0;
        resetn    = 1'b0;
        req       = '0;

        //      cmd   map      addr          slot err     host bank
        add_row(WR_H, 10'h000, 32'h0000_0040, 0, E_OK,    1, 0);
        add_row(RD_H, 10'h000, 32'h0000_0040, 0, E_OK,    1, 0);
        add_row(WR_H, 10'h000, 32'h0000_03fc, 1, E_OK,    1, 0);
        add_row(RD_H, 10'h000, 32'h0000_03fc, 1, E_OK,    1, 0);
        add_row(WR_B, 10'h205, 32'h0000_0100, 2, E_OK,    1, 1);
        add_row(RD_B, 10'h004, 32'h0000_0100, 2, E_OK,    1, 1);
        add_row(WR_B, 10'h3ff, 32'h0000_0084, 3, E_OK,    1, 1);
        add_row(RD_B, 10'h200, 32'h0000_0084, 3, E_OK,    1, 1);
        add_row(RD_B, 10'h000, 32'h0000_0100, 0, E_BANK,  0, 0);
        add_row(RD_B, 10'h003, 32'h0000_0100, 0, E_BANK,  0, 0);
        add_row(WR_B, 10'h000, 32'h0000_0100, 0, E_BANK,  0, 0);
        add_row(WR_H, 10'h000, 32'h0010_0000, 0, E_ADDR,  0, 0);
        add_row(RD_H, 10'h000, 32'hffff_fffc, 0, E_ADDR,  0, 0);
        add_row(RD_H, 10'h000, 32'h0000_0042, 0, E_ALIGN, 0, 0);
        add_row(WR_B, 10'h001, 32'h0000_0101, 0, E_ALIGN, 0, 0);
        add_row(RD_B, 10'h011, 32'h0020_0000, 0, E_BANK,  0, 0);
        add_row(WR_B, 10'h000, 32'h0000_0003, 0, E_BANK,  0, 0);
        add_row(3'd5, 10'h000, 32'h0000_0040, 0, E_CMD,   0, 0);
        add_row(3'd7, 10'h001, 32'h0000_0040, 0, E_CMD,   0, 0);
        add_row(RD_H, 10'h000, 32'h0000_0040, 0, E_OK,    1, 0);
        n_tests = table_q.size();

        repeat (RESET_CLKS) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        // State right after reset
        check_value("idle after reset", rsp.idle, 1'b1);
        check_value("host_csn after reset", host_csn, 1'b1);
        check_value("bank_csn after reset", bank_csn, 1'b1);
        check_value("sck after reset", sck, 1'b0);
        check_value("mosi after reset", mosi, 4'h0);
        n_run++;
        if (err_count == 0) begin
            $display("reset: ok");
        end else begin
            n_bad++;
            $display("reset: mismatch");
        end

        for (int i = 0; i < n_tests; i++) begin
            apply_row(table_q[i], i);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches", n_run, n_run - n_bad,
                 n_bad, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* rtl/qspi_bus_pkg.sv */
package qspi_bus_pkg;

    // ====================
    // Clocking and timing
    // ====================

    // System clock and serial clock rates
    localparam int CLK_HZ = 250_000_000;
    localparam int SCK_HZ = 25_000_000;

    // clk cycles in each half of an sck period
    localparam int HALF_PERIOD_CLKS = CLK_HZ / SCK_HZ / 2;

    // Chip select setup and hold time, converted to clk cycles
    localparam int CS_DELAY_NS   = 60;
    localparam int CS_DELAY_CLKS = CS_DELAY_NS * (CLK_HZ / 1_000_000) / 1000;

    // Serial clocks per transaction field
    localparam int OPCODE_CLKS = 8;
    localparam int ADDR_CLKS   = 8;
    localparam int DATA_CLKS   = 8;
    localparam int TAT_CLKS    = 16;

    // Whole register transactions
    localparam int WREG_CLKS = OPCODE_CLKS + ADDR_CLKS + DATA_CLKS;
    localparam int RREG_CLKS = OPCODE_CLKS + ADDR_CLKS + TAT_CLKS + DATA_CLKS;

    // GenX opcodes
    localparam logic [7:0] OP_WRITE_SINGLE = 8'h02;
    localparam logic [7:0] OP_READ_SINGLE  = 8'h03;

    // ====================
    // Types
    // ====================

    typedef logic [3:0] nybble_t;
    typedef logic [5:0] sck_count_t;

    typedef enum logic [1:0] {
        CS_NONE,
        CS_HOST,
        CS_BANK
    } chip_sel_e;

    // One transaction as handed to the shifter, fields already in wire order
    typedef struct packed {
        chip_sel_e   cs;
        logic [31:0] opcode;
        logic [31:0] addr;
        logic [31:0] data;
        sck_count_t  cycles;
    } qspi_tx_t;

endpackage

/* rtl/qspi_cmd_fsm.sv */
`timescale 1ns/100ps

module qspi_cmd_fsm (
    input  logic                     clk,
    input  logic                     resetn,
    input  qspi_cmd_pkg::qspi_req_t  req,
    output qspi_cmd_pkg::qspi_rsp_t  rsp,
    output qspi_bus_pkg::qspi_tx_t   tx,
    output logic                     tx_start,
    input  logic                     tx_idle,
    input  qspi_cmd_pkg::qspi_word_t rd_word
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BANK_SEL,
        ST_ACCESS,
        ST_END
    } state_e;

    state_e                   state;
    qspi_cmd_pkg::qspi_req_t  req_q;
    qspi_cmd_pkg::qspi_err_e  err_q;
    qspi_cmd_pkg::qspi_err_e  addr_err;
    qspi_cmd_pkg::qspi_err_e  chk_err;
    qspi_cmd_pkg::qspi_word_t rdata_q;
    logic [$clog2(qspi_cmd_pkg::NUM_BANKS + 1)-1:0] bank_count;
    logic chk_bank;
    logic q_bank;
    logic q_read;

    // Opcode bits land in bit 0 of each nybble, MSB first
    function automatic qspi_cmd_pkg::qspi_word_t make_opcode(input logic [7:0] op);
        qspi_cmd_pkg::qspi_word_t w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            w[4*i] = op[i];
        end
        return w;
    endfunction

    // GenX wants address and data little-endian on the wire
    function automatic qspi_cmd_pkg::qspi_word_t swap_endian(input qspi_cmd_pkg::qspi_word_t v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    assign chk_bank = (req.cmd == qspi_cmd_pkg::CMD_WR_BREG) ||
                      (req.cmd == qspi_cmd_pkg::CMD_RD_BREG);
    assign q_bank = (req_q.cmd == qspi_cmd_pkg::CMD_WR_BREG) ||
                    (req_q.cmd == qspi_cmd_pkg::CMD_RD_BREG);
    assign q_read = (req_q.cmd == qspi_cmd_pkg::CMD_RD_HREG) ||
                    (req_q.cmd == qspi_cmd_pkg::CMD_RD_BREG);

    // ====================
    // Parameter checks
    // ====================
    always_comb begin
        bank_count = '0;
        for (int i = 0; i < qspi_cmd_pkg::NUM_BANKS; i++) begin
            bank_count = bank_count + req.bankmap[i];
        end

        // Range before alignment
        addr_err = qspi_cmd_pkg::ERR_NONE;
        if (req.addr >= qspi_cmd_pkg::FIRST_SMEM_ADDR) begin
            addr_err = qspi_cmd_pkg::ERR_ADDRESS;
        end else if (req.addr[1:0] != 2'b00) begin
            addr_err = qspi_cmd_pkg::ERR_UNALIGNED;
        end

        // Bank selection errors take priority over address errors
        case (req.cmd)
            qspi_cmd_pkg::CMD_WR_HREG,
            qspi_cmd_pkg::CMD_RD_HREG: chk_err = addr_err;
            qspi_cmd_pkg::CMD_WR_BREG:
                chk_err = (bank_count == 0) ? qspi_cmd_pkg::ERR_BANKSEL : addr_err;
            qspi_cmd_pkg::CMD_RD_BREG:
                chk_err = (bank_count != 1) ? qspi_cmd_pkg::ERR_BANKSEL : addr_err;
            default: chk_err = qspi_cmd_pkg::ERR_BAD_CMD;
        endcase
    end

    // Busy as soon as start arrives, even if it gets rejected
    always_comb begin
        rsp.rdata = rdata_q;
        rsp.err   = err_q;
        rsp.idle  = (state == ST_IDLE) && !req.start;
    end

    // ====================
    // Command sequencer
    // ====================
    always_ff @(posedge clk) begin
        // One clk strobe
        tx_start <= 1'b0;
        if (!resetn) begin
            state <= ST_IDLE;
            err_q <= qspi_cmd_pkg::ERR_NONE;
        end else begin
            case (state)
                ST_IDLE:
                    if (req.start) begin
                        req_q <= req;
                        err_q <= chk_err;
                        if (chk_err == qspi_cmd_pkg::ERR_NONE) begin
                            state <= chk_bank ? ST_BANK_SEL : ST_ACCESS;
                        end
                    end

                // Write the bank map into the bank enable register
                ST_BANK_SEL:
                    if (tx_idle) begin
                        tx.cs     <= qspi_bus_pkg::CS_HOST;
                        tx.opcode <= make_opcode(qspi_bus_pkg::OP_WRITE_SINGLE);
                        tx.addr   <= swap_endian(qspi_cmd_pkg::BANK_EN_REG);
                        tx.data   <= swap_endian(qspi_cmd_pkg::qspi_word_t'(req_q.bankmap));
                        tx.cycles <= qspi_bus_pkg::sck_count_t'(qspi_bus_pkg::WREG_CLKS);
                        tx_start  <= 1'b1;
                        state     <= ST_ACCESS;
                    end

                // The register access itself
                ST_ACCESS:
                    if (tx_idle) begin
                        tx.cs     <= q_bank ? qspi_bus_pkg::CS_BANK : qspi_bus_pkg::CS_HOST;
                        tx.opcode <= make_opcode(q_read ? qspi_bus_pkg::OP_READ_SINGLE
                                                        : qspi_bus_pkg::OP_WRITE_SINGLE);
                        tx.addr   <= swap_endian(req_q.addr);
                        tx.data   <= q_read ? '0 : swap_endian(req_q.wdata);
                        tx.cycles <= qspi_bus_pkg::sck_count_t'(q_read ? qspi_bus_pkg::RREG_CLKS
                                                                       : qspi_bus_pkg::WREG_CLKS);
                        tx_start  <= 1'b1;
                        state     <= ST_END;
                    end

                // Wait out the last transaction, then return read data
                ST_END:
                    if (tx_idle) begin
                        if (q_read) begin
                            rdata_q <= swap_endian(rd_word);
                        end
                        state <= ST_IDLE;
                    end
            endcase
        end
    end

endmodule

/* rtl/qspi_cmd_pkg.sv */
package qspi_cmd_pkg;

    // Number of GenX banks addressable through the bank map
    localparam int NUM_BANKS = 10;

    // ====================
    // Types
    // ====================

    typedef logic [31:0]          qspi_addr_t;
    typedef logic [31:0]          qspi_word_t;
    typedef logic [NUM_BANKS-1:0] bankmap_t;

    // Client commands
    // Codes 4 to 7 are not defined and get rejected
    typedef enum logic [2:0] {
        CMD_WR_HREG = 3'd0,
        CMD_RD_HREG = 3'd1,
        CMD_WR_BREG = 3'd2,
        CMD_RD_BREG = 3'd3
    } qspi_cmd_e;

    // Parameter check results
    typedef enum logic [2:0] {
        ERR_NONE      = 3'd0,
        ERR_BANKSEL   = 3'd1,
        ERR_ADDRESS   = 3'd2,
        ERR_UNALIGNED = 3'd3,
        ERR_BAD_CMD   = 3'd4
    } qspi_err_e;

    // ====================
    // Address map
    // ====================

    // Host register holding the bank enable map
    localparam qspi_addr_t BANK_EN_REG = 32'h0000_0028;

    // Registers live below this address, SMEM above
    localparam qspi_addr_t FIRST_SMEM_ADDR = 32'h0010_0000;

    // Client request, start is a one clk pulse
    typedef struct packed {
        qspi_cmd_e  cmd;
        bankmap_t   bankmap;
        qspi_addr_t addr;
        qspi_word_t wdata;
        logic       start;
    } qspi_req_t;

    // Client response
    typedef struct packed {
        qspi_word_t rdata;
        qspi_err_e  err;
        logic       idle;
    } qspi_rsp_t;

endpackage

/* rtl/qspi_manager.sv */
`timescale 1ns/100ps

module qspi_manager (
    input  logic                    clk,
    input  logic                    resetn,
    input  qspi_cmd_pkg::qspi_req_t req,
    output qspi_cmd_pkg::qspi_rsp_t rsp,
    output qspi_bus_pkg::nybble_t   mosi,
    input  qspi_bus_pkg::nybble_t   miso,
    output logic                    sck,
    output logic                    host_csn,
    output logic                    bank_csn
);

    // Command handler to shifter
    qspi_bus_pkg::qspi_tx_t   tx;
    logic                     tx_start;
    logic                     tx_idle;
    qspi_cmd_pkg::qspi_word_t rd_word;

    // Shifter to clock generator
    logic                     sck_enable;
    logic                     sck_rise;
    logic                     sck_fall;
    qspi_bus_pkg::sck_count_t sck_cycles;

    // Validates client commands and sequences transactions
    qspi_cmd_fsm u_cmd_fsm (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req),
        .rsp      (rsp),
        .tx       (tx),
        .tx_start (tx_start),
        .tx_idle  (tx_idle),
        .rd_word  (rd_word)
    );

    // Drives one chip select window on the pins
    qspi_shifter u_shifter (
        .clk        (clk),
        .resetn     (resetn),
        .tx         (tx),
        .tx_start   (tx_start),
        .tx_idle    (tx_idle),
        .rd_word    (rd_word),
        .sck_rise   (sck_rise),
        .sck_fall   (sck_fall),
        .sck_cycles (sck_cycles),
        .sck_enable (sck_enable),
        .mosi       (mosi),
        .miso       (miso),
        .host_csn   (host_csn),
        .bank_csn   (bank_csn)
    );

    // Serial clock, running only while the shifter clocks bits
    qspi_sck_gen u_sck_gen (
        .clk    (clk),
        .resetn (resetn),
        .enable (sck_enable),
        .sck    (sck),
        .rise   (sck_rise),
        .fall   (sck_fall),
        .cycles (sck_cycles)
    );

endmodule

/* rtl/qspi_sck_gen.sv */
`timescale 1ns/100ps

module qspi_sck_gen (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    enable,
    output logic                    sck,
    output logic                    rise,
    output logic                    fall,
    output qspi_bus_pkg::sck_count_t cycles
);

    // Position within the current half period
    logic [3:0] half_cnt;
    logic       half_done;

    // Last clk of a half period, sck toggles at the next edge
    assign half_done = enable && (half_cnt == 4'(qspi_bus_pkg::HALF_PERIOD_CLKS - 1));

    // Strobes lead the actual sck edge by one clk
    assign rise = half_done && !sck;
    assign fall = half_done && sck;

    always_ff @(posedge clk) begin
        if (!resetn || !enable) begin
            // Parked low with counts cleared
            half_cnt <= '0;
            sck      <= 1'b0;
            cycles   <= '0;
        end else begin
            if (half_done) begin
                half_cnt <= '0;
                sck      <= !sck;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            // Count completed rising edges
            if (rise) begin
                cycles <= cycles + 1'b1;
            end
        end
    end

endmodule

/* rtl/qspi_shifter.sv */
`timescale 1ns/100ps

module qspi_shifter (
    input  logic                     clk,
    input  logic                     resetn,
    input  qspi_bus_pkg::qspi_tx_t   tx,
    input  logic                     tx_start,
    output logic                     tx_idle,
    output qspi_cmd_pkg::qspi_word_t rd_word,
    input  logic                     sck_rise,
    input  logic                     sck_fall,
    input  qspi_bus_pkg::sck_count_t sck_cycles,
    output logic                     sck_enable,
    output qspi_bus_pkg::nybble_t    mosi,
    input  qspi_bus_pkg::nybble_t    miso,
    output logic                     host_csn,
    output logic                     bank_csn
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ASSERT_CS,
        ST_CLOCKING,
        ST_RELEASE_CS,
        ST_WAIT
    } state_e;

    state_e                   state;
    logic [5:0]               delay;
    logic [95:0]              shift_word;
    qspi_bus_pkg::sck_count_t cycle_limit;
    qspi_bus_pkg::chip_sel_e  cs;

    // A pending start already counts as busy
    assign tx_idle    = (state == ST_IDLE) && !tx_start;
    assign sck_enable = (state == ST_CLOCKING);

    // Chip selects are active low
    assign host_csn = (cs != qspi_bus_pkg::CS_HOST);
    assign bank_csn = (cs != qspi_bus_pkg::CS_BANK);

    // Top nybble goes out first
    // shift_word moves on the same edge that sck falls
    assign mosi = (state == ST_IDLE) ? 4'h0 : shift_word[95:92];

    // ====================
    // Transaction FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
            delay <= '0;
            cs    <= qspi_bus_pkg::CS_NONE;
        end else begin
            case (state)
                ST_IDLE:
                    if (tx_start) begin
                        shift_word  <= {tx.opcode, tx.addr, tx.data};
                        cycle_limit <= tx.cycles;
                        cs          <= tx.cs;
                        // Start cycle is the first clk of the setup delay
                        delay       <= 6'(qspi_bus_pkg::CS_DELAY_CLKS - 2);
                        state       <= ST_ASSERT_CS;
                    end

                // Chip select setup before the first sck edge
                ST_ASSERT_CS:
                    if (delay == '0) begin
                        state <= ST_CLOCKING;
                    end else begin
                        delay <= delay - 1'b1;
                    end

                ST_CLOCKING:
                    if (sck_fall) begin
                        shift_word <= {shift_word[91:0], 4'h0};
                        // Last falling edge of the transaction
                        if (sck_cycles == cycle_limit) begin
                            state <= ST_RELEASE_CS;
                        end
                    end

                ST_RELEASE_CS: begin
                    cs    <= qspi_bus_pkg::CS_NONE;
                    delay <= 6'(qspi_bus_pkg::CS_DELAY_CLKS - 1);
                    state <= ST_WAIT;
                end

                // Hold time after release
                ST_WAIT:
                    if (delay == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        delay <= delay - 1'b1;
                    end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // ====================
    // Read capture
    // ====================
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tx_start) begin
            // Fresh word per transaction, held after it ends
            rd_word <= '0;
        end else if (sck_rise) begin
            rd_word <= {rd_word[27:0], miso};
        end
    end

endmodule

/* tb.f */
rtl/qspi_bus_pkg.sv
rtl/qspi_cmd_pkg.sv
rtl/qspi_sck_gen.sv
rtl/qspi_shifter.sv
rtl/qspi_cmd_fsm.sv
rtl/qspi_manager.sv
bench/genx_qspi_model.sv
bench/tb_qspi_manager.sv
